/* dv/tb_lsu_subsys.sv */
/*
 * Testbench for the load/store subsystem.
 * All accesses stay inside the first 128 bytes, which test 1 fills
 * before anything is read back. A byte model plus an error window
 * model predict load data and err_o, and a word sweep after the
 * window test reads the whole area back.
 * Inputs change 1 ns after a rising edge. Outputs are read at falling
 * edges, and ready_o and done_o once more 1 ns after the closing edge.
 */
`timescale 1ns/1ps
`include "lsu_config.svh"

module tb_lsu_subsys import mem_access_pkg::*, issue_pkg::*; ();

  localparam int CLK_PERIOD = 100;
  localparam int N_FILL     = 32;
  localparam int N_RAND     = 120;
  localparam int N_MIS      = 6;
  localparam int N_WIN      = 80;
  localparam int N_HOLD     = 100;
  // every command of every test plus slack for reset and config writes
  localparam int N_CMDS     = 3*N_FILL + N_RAND + 16*N_MIS + N_WIN + N_HOLD + 16;
  localparam longint WATCHDOG_NS = longint'(N_CMDS) * 20 * CLK_PERIOD;

  logic        clk;
  logic        rst_n;
  logic        cmd_valid;
  cmd_op_e     cmd_op;
  mem_size_e   cmd_size;
  logic        cmd_sext;
  logic [31:0] cmd_base;
  logic [31:0] cmd_offset;
  logic [31:0] cmd_wdata;
  logic        hold;
  logic        cfg_we;
  logic        cfg_sel;
  logic [31:0] cfg_wdata;
  logic        ready_o;
  logic        done_o;
  logic [31:0] rdata_o;
  logic        err_o;

  // reference state
  logic [7:0]  mem_model [0:1023];
  logic [31:0] win_base;
  logic [31:0] win_limit;
  logic [31:0] rng_q;
  logic        hold_mode;
  int          err_cnt;
  int          check_cnt;
  int          test_cnt;
  int          test_err0;

  lsu_subsys UUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_valid_i  (cmd_valid),
    .cmd_op_i     (cmd_op),
    .cmd_size_i   (cmd_size),
    .cmd_sext_i   (cmd_sext),
    .cmd_base_i   (cmd_base),
    .cmd_offset_i (cmd_offset),
    .cmd_wdata_i  (cmd_wdata),
    .hold_i       (hold),
    .cfg_we_i     (cfg_we),
    .cfg_sel_i    (cfg_sel),
    .cfg_wdata_i  (cfg_wdata),
    .ready_o      (ready_o),
    .done_o       (done_o),
    .rdata_o      (rdata_o),
    .err_o        (err_o)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD/2) clk = ~clk;

  //////////////////////////////////////////////////
  // random source and reference model
  //////////////////////////////////////////////////
  function automatic logic [31:0] xorshift_next();
    logic [31:0] x;
    x = rng_q;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_q = x;
    return x;
  endfunction

  // fill value mixes every address bit
  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return (a * 32'h9E37_79B9) ^ {a[15:0], a[31:16]} ^ 32'h0F1E_2D3C;
  endfunction

  function automatic int size_bytes(input mem_size_e sz);
    case (sz)
      SIZE_BYTE: return 1;
      SIZE_HALF: return 2;
      default:   return 4;
    endcase
  endfunction

  // window is checked per word with inclusive bounds
  function automatic logic in_window(input logic [31:0] addr);
    logic [31:0] w;
    w = {addr[31:2], 2'b00};
    return (w >= win_base) && (w <= win_limit);
  endfunction

  function automatic logic [31:0] model_load(input logic [31:0] addr, input mem_size_e sz,
                                             input logic sx);
    logic [31:0] v;
    int          n;
    n = size_bytes(sz);
    v = '0;
    // little endian over 1 KB of memory that aliases
    for (int i = 0; i < n; i++) begin
      v[8*i +: 8] = mem_model[10'(addr + 32'(i))];
    end
    if (sx && n == 1) begin
      v = {{24{v[7]}}, v[7:0]};
    end else if (sx && n == 2) begin
      v = {{16{v[15]}}, v[15:0]};
    end
    return v;
  endfunction

  // bytes whose word lies in the window are never written
  task automatic model_store(input logic [31:0] addr, input mem_size_e sz,
                             input logic [31:0] wd);
    for (int i = 0; i < size_bytes(sz); i++) begin
      if (!in_window(addr + 32'(i))) begin
        mem_model[10'(addr + 32'(i))] = wd[8*i +: 8];
      end
    end
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %s got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  //////////////////////////////////////////////////
  // drivers
  //////////////////////////////////////////////////
  task automatic drive_hold();
    logic [31:0] r;
    r = xorshift_next();
    hold = hold_mode & r[0];
  endtask

  // one command from strobe to done_o, entered and left 1 ns after a rising edge
  task automatic run_access(input cmd_op_e op, input mem_size_e sz, input logic sx,
                            input logic [31:0] addr, input logic [31:0] wd);
    logic [31:0] exp_rd;
    logic        exp_err;
    logic        misal;
    logic [31:0] base;
    int          lat;
    exp_rd  = model_load(addr, sz, sx);
    exp_err = in_window(addr) || in_window(addr + 32'(size_bytes(sz)) - 32'd1);
    // word crossing or halfword in the top byte needs two accesses
    misal   = (sz == SIZE_WORD && addr[1:0] != 2'b00) || (sz == SIZE_HALF && addr[1:0] == 2'b11);
    // random base lets the adder see carries and negative offsets
    base    = xorshift_next();
    while (!ready_o) begin
      @(posedge clk);
      #1;
    end
    cmd_valid  = 1'b1;
    cmd_op     = op;
    cmd_size   = sz;
    cmd_sext   = sx;
    cmd_base   = base;
    cmd_offset = addr - base;
    cmd_wdata  = wd;
    drive_hold();
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
    if (op == OP_STORE) begin
      model_store(addr, sz, wd);
    end
    lat = 0;
    @(negedge clk);
    while (!done_o) begin
      check_val("ready_o", 32'(ready_o), 32'd0);
      @(posedge clk);
      #1;
      drive_hold();
      lat++;
      @(negedge clk);
    end
    check_val("ready_o", 32'(ready_o), 32'd0);
    if (op == OP_LOAD) begin
      check_val("rdata_o", rdata_o, exp_rd);
    end
    check_val("err_o", 32'(err_o), 32'(exp_err));
    if (!hold_mode) begin
      check_val("done_o latency", 32'(lat), misal ? 32'd2 : 32'd1);
    end
    @(posedge clk);
    #1;
    // one-cycle done pulse and ready again right after it
    check_val("ready_o", 32'(ready_o), 32'd1);
    check_val("done_o", 32'(done_o), 32'd0);
    drive_hold();
  endtask

  task automatic rand_access(input logic any_size);
    logic [31:0] r;
    mem_size_e   sz;
    r  = xorshift_next();
    sz = r[2] ? SIZE_HALF : SIZE_BYTE;
    if (any_size && r[3]) begin
      sz = SIZE_WORD;
    end
    // byte 123 plus three still lands in the filled area
    run_access(r[4] ? OP_STORE : OP_LOAD, sz, r[5], (r >> 8) % 124, xorshift_next());
  endtask

  task automatic write_cfg(input logic sel, input logic [31:0] val);
    cfg_we    = 1'b1;
    cfg_sel   = sel;
    cfg_wdata = val;
    @(posedge clk);
    #1;
    cfg_we = 1'b0;
    if (sel) begin
      win_limit = {val[31:2], 2'b00};
    end else begin
      win_base = {val[31:2], 2'b00};
    end
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - test_err0);
    test_err0 = err_cnt;
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////
  initial begin
    logic [31:0] r;
    logic [31:0] w;
    mem_size_e   sz;
    rng_q      = 32'd56310;
    hold_mode  = 1'b0;
    err_cnt    = 0;
    check_cnt  = 0;
    test_cnt   = 0;
    test_err0  = 0;
    win_base   = `ERR_BASE_RST;
    win_limit  = `ERR_LIMIT_RST;
    cmd_valid  = 1'b0;
    cmd_op     = OP_LOAD;
    cmd_size   = SIZE_WORD;
    cmd_sext   = 1'b0;
    cmd_base   = '0;
    cmd_offset = '0;
    cmd_wdata  = '0;
    hold       = 1'b0;
    cfg_we     = 1'b0;
    cfg_sel    = 1'b0;
    cfg_wdata  = '0;
    rst_n      = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // aligned words fill the area and are read back
    for (int i = 0; i < N_FILL; i++) begin
      run_access(OP_STORE, SIZE_WORD, 1'b0, 32'(4*i), fill_word(32'(4*i)));
    end
    for (int i = 0; i < N_FILL; i++) begin
      run_access(OP_LOAD, SIZE_WORD, 1'b0, 32'(4*i), 32'h0);
    end
    end_test("aligned words");

    repeat (N_RAND) rand_access(1'b0);
    end_test("random bytes and halfwords");

    // each split case followed by both touched words to see the neighbours
    for (int k = 0; k < N_MIS; k++) begin
      for (int c = 0; c < 4; c++) begin
        r  = xorshift_next();
        w  = 4 * (r % 30);
        sz = (c == 3) ? SIZE_HALF : SIZE_WORD;
        run_access(OP_STORE, sz, 1'b0, w + ((c == 3) ? 3 : c + 1), xorshift_next());
        run_access(OP_LOAD, sz, r[31], w + ((c == 3) ? 3 : c + 1), 32'h0);
        run_access(OP_LOAD, SIZE_WORD, 1'b0, w, 32'h0);
        run_access(OP_LOAD, SIZE_WORD, 1'b0, w + 4, 32'h0);
      end
    end
    end_test("misaligned accesses");

    // window over words 0x20 to 0x2c with the low bits of the writes dropped
    write_cfg(1'b0, 32'h0000_0021);
    write_cfg(1'b1, 32'h0000_002E);
    repeat (N_WIN) rand_access(1'b1);
    // blocked stores must have left the window words as they were
    for (int i = 0; i < N_FILL; i++) begin
      run_access(OP_LOAD, SIZE_WORD, 1'b0, 32'(4*i), 32'h0);
    end
    end_test("error window");

    hold_mode = 1'b1;
    repeat (N_HOLD) rand_access(1'b1);
    hold_mode = 1'b0;
    hold      = 1'b0;
    end_test("random hold");

    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // bound on the whole run at 20 cycles per command
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, a command never completed", WATCHDOG_NS);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

/* hdl/data_sram.sv */
/*
 * Word-addressed data memory with byte enables.
 * Every request is granted in its own cycle; rvalid and read data follow
 * one cycle later. Upper address bits beyond the depth alias.
 * Accesses to a word inside [base, limit] raise err_o with the grant,
 * stores there are dropped, and loads still return the stored word.
 */
`timescale 1ns/1ps
`include "lsu_config.svh"

module data_sram (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_i,
  input  logic [`LSU_DATA_W-1:0] addr_i,
  input  logic                   we_i,
  input  logic [3:0]             be_i,
  input  logic [`LSU_DATA_W-1:0] wdata_i,
  input  logic [`LSU_DATA_W-1:0] err_base_i,
  input  logic [`LSU_DATA_W-1:0] err_limit_i,
  output logic                   gnt_o,
  output logic                   rvalid_o,
  output logic [`LSU_DATA_W-1:0] rdata_o,
  output logic                   err_o
);

  logic [`LSU_DATA_W-1:0]      mem [0:(1 << `SRAM_DEPTH_LOG2)-1];
  logic [`SRAM_DEPTH_LOG2-1:0] word_idx;
  logic [`LSU_DATA_W-1:0]      word_addr;
  logic                        in_window;

  assign word_idx  = addr_i[`SRAM_DEPTH_LOG2+1:2];
  // window check on the word, so split accesses see their own word
  assign word_addr = {addr_i[`LSU_DATA_W-1:2], 2'b00};
  assign in_window = (word_addr >= err_base_i) && (word_addr <= err_limit_i);

  // no back-pressure
  assign gnt_o = req_i;
  assign err_o = req_i && in_window;

  ////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (req_i && we_i && !in_window) begin
      for (int b = 0; b < 4; b++) begin
        if (be_i[b]) begin
          mem[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // read data for every request, old contents on a write
  always_ff @(posedge clk) begin
    if (req_i) begin
      rdata_o <= mem[word_idx];
    end
  end

  // one response per granted request
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= req_i;
    end
  end

endmodule

/* hdl/issue_pkg.sv */
/*
 * Types of the command side: the operation code of a command
 * and the state of the issue controller.
 */
package issue_pkg;

  // command operation
  typedef enum logic {
    OP_LOAD  = 1'b0,
    OP_STORE = 1'b1
  } cmd_op_e;

  // issue controller state
  // first and second refer to the accesses of one command
  typedef enum logic [1:0] {
    ISS_IDLE,
    ISS_FIRST,
    ISS_SECOND
  } issue_state_e;

endpackage

/* hdl/load_store_unit.sv */
/*
 * Load/store unit between the EX stage and a req/gnt/rvalid data memory.
 * Misaligned words and halfwords at offset 3 take two accesses; the caller
 * replays the second one with data_misaligned_ex_i high and an address in
 * the next word. Second-access byte enables cover the remaining bytes only.
 * Exactly one response is expected per granted request.
 */
`timescale 1ns/1ps
`include "lsu_config.svh"

module load_store_unit import mem_access_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  // data memory side
  output logic                   data_req_o,
  input  logic                   data_gnt_i,
  input  logic                   data_rvalid_i,
  input  logic                   data_err_i,
  output logic [`LSU_DATA_W-1:0] data_addr_o,
  output logic                   data_we_o,
  output logic [3:0]             data_be_o,
  output logic [`LSU_DATA_W-1:0] data_wdata_o,
  input  logic [`LSU_DATA_W-1:0] data_rdata_i,
  // EX stage side
  input  logic                   data_we_ex_i,
  input  mem_size_e              data_type_ex_i,
  input  logic [`LSU_DATA_W-1:0] data_wdata_ex_i,
  input  logic                   data_sign_ext_ex_i,
  output logic [`LSU_DATA_W-1:0] data_rdata_ex_o,
  input  logic                   data_req_ex_i,
  input  logic [`LSU_DATA_W-1:0] operand_a_ex_i,
  input  logic [`LSU_DATA_W-1:0] operand_b_ex_i,
  input  logic                   addr_useincr_ex_i,
  input  logic                   data_misaligned_ex_i,
  output logic                   data_misaligned_o,
  // exceptions
  output logic                   load_err_o,
  output logic                   store_err_o,
  // stall handshake
  output logic                   lsu_ready_ex_o,
  output logic                   lsu_ready_wb_o,
  input  logic                   ex_valid_i,
  output logic                   busy_o
);

  lsu_state_e               state_q, state_d;
  resp_kind_e               resp_q, resp_d;
  logic [`LSU_DATA_W-1:0]   addr_sum;
  logic [1:0]               shamt;
  logic [3:0]               be_base;
  logic [7:0]               be_wide;
  logic [2*`LSU_DATA_W-1:0] wdata_dbl;
  logic                     can_issue;
  // request attributes kept for the response
  logic [3:0]               mask_q;
  logic [1:0]               shamt_q;
  mem_size_e                type_q;
  logic                     sign_ext_q;
  logic [`LSU_DATA_W-1:0]   masked;
  logic [`LSU_DATA_W-1:0]   rdata_new;
  logic [`LSU_DATA_W-1:0]   rdata_q;

  ////////////////////////////////////////////////////
  // address, byte enables and store data
  ////////////////////////////////////////////////////
  assign addr_sum = addr_useincr_ex_i ? operand_a_ex_i + operand_b_ex_i : operand_a_ex_i;
  assign shamt    = addr_sum[1:0];
  // second access always starts at byte 0 of the next word
  assign data_addr_o = data_misaligned_ex_i ? {addr_sum[`LSU_DATA_W-1:2], 2'b00} : addr_sum;

  always_comb begin
    case (data_type_ex_i)
      SIZE_BYTE: be_base = 4'b0001;
      SIZE_HALF: be_base = 4'b0011;
      default:   be_base = 4'b1111;
    endcase
    // lanes spilling past byte 3 belong to the second access
    be_wide   = {4'b0000, be_base} << shamt;
    data_be_o = data_misaligned_ex_i ? be_wide[7:4] : be_wide[3:0];
  end

  // rotate store data left by the byte offset
  assign wdata_dbl    = {data_wdata_ex_i, data_wdata_ex_i} << {shamt, 3'b000};
  assign data_wdata_o = wdata_dbl[2*`LSU_DATA_W-1:`LSU_DATA_W];
  assign data_we_o    = data_we_ex_i;

  // word crossing a boundary, or halfword in the top byte
  always_comb begin
    data_misaligned_o = 1'b0;
    if (data_req_ex_i && !data_misaligned_ex_i) begin
      case (data_type_ex_i)
        SIZE_WORD: data_misaligned_o = (shamt != 2'b00);
        SIZE_HALF: data_misaligned_o = (shamt == 2'b11);
        default:   data_misaligned_o = 1'b0;
      endcase
    end
  end

  assign load_err_o  = data_gnt_i && data_err_i && !data_we_o;
  assign store_err_o = data_gnt_i && data_err_i && data_we_o;

  ////////////////////////////////////////////////////
  // response tracking and load data rebuild
  ////////////////////////////////////////////////////
  always_comb begin
    resp_d = resp_q;
    if (data_req_o && data_gnt_i && data_misaligned_o) begin
      resp_d = RESP_MISALIGNED;
    end else if (data_rvalid_i) begin
      resp_d = (resp_q == RESP_MISALIGNED) ? RESP_ALIGNED : RESP_REGULAR;
    end
  end

  always_comb begin
    masked = data_rdata_i & {{8{mask_q[3]}}, {8{mask_q[2]}}, {8{mask_q[1]}}, {8{mask_q[0]}}};
    if (resp_q == RESP_ALIGNED) begin
      // upper bytes of a split access join the lower part from the first response
      rdata_new = (masked << (6'd32 - {shamt_q, 3'b000})) | rdata_q;
    end else begin
      rdata_new = masked >> {shamt_q, 3'b000};
    end
    // extend only once the value is complete
    if (sign_ext_q && resp_q != RESP_MISALIGNED) begin
      case (type_q)
        SIZE_BYTE: rdata_new = {{24{rdata_new[7]}}, rdata_new[7:0]};
        SIZE_HALF: rdata_new = {{16{rdata_new[15]}}, rdata_new[15:0]};
        default:   rdata_new = rdata_new;
      endcase
    end
  end

  assign data_rdata_ex_o = data_rvalid_i ? rdata_new : rdata_q;

  ////////////////////////////////////////////////////
  // request/response FSM
  ////////////////////////////////////////////////////
  always_comb begin
    state_d        = state_q;
    data_req_o     = 1'b0;
    lsu_ready_ex_o = 1'b1;
    lsu_ready_wb_o = 1'b1;
    can_issue      = 1'b0;
    case (state_q)
      IDLE: can_issue = 1'b1;
      // WB stalls until the response, which also frees the port
      WAIT_RVALID: begin
        lsu_ready_wb_o = data_rvalid_i;
        can_issue      = data_rvalid_i;
      end
      // EX held, no new request until it moves
      WAIT_RVALID_EX_STALL: begin
        if (data_rvalid_i) begin
          state_d = ex_valid_i ? IDLE : IDLE_EX_STALL;
        end else if (ex_valid_i) begin
          state_d = WAIT_RVALID;
        end
      end
      IDLE_EX_STALL: begin
        if (ex_valid_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
    if (can_issue) begin
      data_req_o = data_req_ex_i;
      if (data_req_ex_i && data_gnt_i) begin
        state_d = ex_valid_i ? WAIT_RVALID : WAIT_RVALID_EX_STALL;
      end else begin
        lsu_ready_ex_o = !data_req_ex_i;
        state_d        = IDLE;
      end
    end
  end

  assign busy_o = (state_q != IDLE) || data_req_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      resp_q  <= RESP_REGULAR;
    end else begin
      state_q <= state_d;
      resp_q  <= resp_d;
    end
  end

  // attributes follow each granted request, data each response
  always_ff @(posedge clk) begin
    if (data_req_o && data_gnt_i) begin
      mask_q     <= data_be_o;
      shamt_q    <= shamt;
      type_q     <= data_type_ex_i;
      sign_ext_q <= data_sign_ext_ex_i;
    end
    if (data_rvalid_i) begin
      rdata_q <= rdata_new;
    end
  end

endmodule

/* hdl/lsu_config.svh */
/*
 * Shared sizing and reset values for the load/store subsystem.
 * The error window bounds are inclusive and word aligned.
 * At reset the window is empty because base sits above limit.
 */
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// data and address width in bits
`define LSU_DATA_W 32

// word address bits of the data memory, 256 words
`define SRAM_DEPTH_LOG2 8

// error window reset values, base above limit disables the check
`define ERR_BASE_RST  32'hFFFF_FFFC
`define ERR_LIMIT_RST 32'h0000_0000

`endif

/* hdl/lsu_issue_ctrl.sv */
/*
 * Issue controller standing in for the ID/EX stage of a small core.
 * One command at a time; new commands are taken only while ready_o is high.
 * An access leaves EX on an edge where the LSU is ready in EX and WB
 * and hold_i is low. The misaligned replay follows the LSU's flag only.
 */
`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_issue_ctrl import mem_access_pkg::*, issue_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  // command port
  input  logic                   cmd_valid_i,
  input  cmd_op_e                cmd_op_i,
  input  mem_size_e              cmd_size_i,
  input  logic                   cmd_sext_i,
  input  logic [`LSU_DATA_W-1:0] cmd_base_i,
  input  logic [`LSU_DATA_W-1:0] cmd_offset_i,
  input  logic [`LSU_DATA_W-1:0] cmd_wdata_i,
  input  logic                   hold_i,
  output logic                   ready_o,
  output logic                   done_o,
  output logic                   err_o,
  // EX-side signals toward the LSU
  output logic                   data_req_ex_o,
  output logic                   data_we_ex_o,
  output mem_size_e              data_type_ex_o,
  output logic                   data_sign_ext_ex_o,
  output logic [`LSU_DATA_W-1:0] data_wdata_ex_o,
  output logic [`LSU_DATA_W-1:0] operand_a_ex_o,
  output logic [`LSU_DATA_W-1:0] operand_b_ex_o,
  output logic                   data_misaligned_ex_o,
  output logic                   ex_valid_o,
  // status from the LSU
  input  logic                   lsu_ready_ex_i,
  input  logic                   lsu_ready_wb_i,
  input  logic                   data_misaligned_i,
  input  logic                   load_err_i,
  input  logic                   store_err_i
);

  issue_state_e           state_q;
  // set once the last access of the command has left EX
  logic                   handed_q;
  logic                   err_q;
  logic                   handshake;
  cmd_op_e                op_q;
  mem_size_e              size_q;
  logic                   sext_q;
  logic [`LSU_DATA_W-1:0] base_q;
  logic [`LSU_DATA_W-1:0] offset_q;
  logic [`LSU_DATA_W-1:0] wdata_q;

  ////////////////////////////////////////////////////
  // EX stage view of the held command
  ////////////////////////////////////////////////////
  assign ready_o              = (state_q == ISS_IDLE);
  assign data_req_ex_o        = (state_q != ISS_IDLE) && !handed_q;
  assign data_misaligned_ex_o = (state_q == ISS_SECOND);
  assign data_we_ex_o         = (op_q == OP_STORE);
  assign data_type_ex_o       = size_q;
  assign data_sign_ext_ex_o   = sext_q;
  assign data_wdata_ex_o      = wdata_q;
  assign operand_a_ex_o       = base_q;
  // second access points at the next word, low bits unchanged
  assign operand_b_ex_o       = data_misaligned_ex_o ? offset_q + `LSU_DATA_W'(4) : offset_q;
  assign ex_valid_o           = ~hold_i;

  // access leaves EX only when both LSU stages accept and EX is not stalled
  assign handshake = data_req_ex_o && lsu_ready_ex_i && lsu_ready_wb_i && !hold_i;

  // completion once WB is free again after the last access
  assign done_o = handed_q && lsu_ready_wb_i;
  assign err_o  = done_o && err_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= ISS_IDLE;
      handed_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      // errors arrive with each grant, collect over both accesses
      if (load_err_i || store_err_i) begin
        err_q <= 1'b1;
      end
      case (state_q)
        ISS_IDLE: begin
          if (cmd_valid_i) begin
            state_q  <= ISS_FIRST;
            handed_q <= 1'b0;
            err_q    <= 1'b0;
          end
        end
        ISS_FIRST: begin
          if (handshake) begin
            if (data_misaligned_i) begin
              state_q <= ISS_SECOND;
            end else begin
              handed_q <= 1'b1;
            end
          end
        end
        ISS_SECOND: begin
          if (handshake) begin
            handed_q <= 1'b1;
          end
        end
        default: state_q <= ISS_IDLE;
      endcase
      if (done_o) begin
        state_q  <= ISS_IDLE;
        handed_q <= 1'b0;
      end
    end
  end

  // command fields, captured on the accepting edge
  always_ff @(posedge clk) begin
    if (ready_o && cmd_valid_i) begin
      op_q     <= cmd_op_i;
      size_q   <= cmd_size_i;
      sext_q   <= cmd_sext_i;
      base_q   <= cmd_base_i;
      offset_q <= cmd_offset_i;
      wdata_q  <= cmd_wdata_i;
    end
  end

endmodule

/* hdl/lsu_subsys.sv */
/*
 * Load/store subsystem top: issue controller, LSU, data memory and
 * the error window registers. The LSU always adds base and offset.
 * Commands are accepted only while ready_o is high.
 */
`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_subsys import mem_access_pkg::*, issue_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   cmd_valid_i,
  input  cmd_op_e                cmd_op_i,
  input  mem_size_e              cmd_size_i,
  input  logic                   cmd_sext_i,
  input  logic [`LSU_DATA_W-1:0] cmd_base_i,
  input  logic [`LSU_DATA_W-1:0] cmd_offset_i,
  input  logic [`LSU_DATA_W-1:0] cmd_wdata_i,
  input  logic                   hold_i,
  input  logic                   cfg_we_i,
  input  logic                   cfg_sel_i,
  input  logic [`LSU_DATA_W-1:0] cfg_wdata_i,
  output logic                   ready_o,
  output logic                   done_o,
  output logic [`LSU_DATA_W-1:0] rdata_o,
  output logic                   err_o
);

  // EX stage to LSU
  logic                   req_ex, we_ex, sext_ex, misal_ex, ex_valid;
  mem_size_e              type_ex;
  logic [`LSU_DATA_W-1:0] wdata_ex, op_a_ex, op_b_ex;
  // LSU status back to the controller
  logic                   ready_ex, ready_wb, misal, load_err, store_err;
  // LSU to memory
  logic                   mem_req, mem_gnt, mem_rvalid, mem_err, mem_we;
  logic [3:0]             mem_be;
  logic [`LSU_DATA_W-1:0] mem_addr, mem_wdata, mem_rdata;
  logic [`LSU_DATA_W-1:0] err_base, err_limit;

  lsu_issue_ctrl u_issue (
    .clk                  (clk),
    .rst_n                (rst_n),
    .cmd_valid_i          (cmd_valid_i),
    .cmd_op_i             (cmd_op_i),
    .cmd_size_i           (cmd_size_i),
    .cmd_sext_i           (cmd_sext_i),
    .cmd_base_i           (cmd_base_i),
    .cmd_offset_i         (cmd_offset_i),
    .cmd_wdata_i          (cmd_wdata_i),
    .hold_i               (hold_i),
    .ready_o              (ready_o),
    .done_o               (done_o),
    .err_o                (err_o),
    .data_req_ex_o        (req_ex),
    .data_we_ex_o         (we_ex),
    .data_type_ex_o       (type_ex),
    .data_sign_ext_ex_o   (sext_ex),
    .data_wdata_ex_o      (wdata_ex),
    .operand_a_ex_o       (op_a_ex),
    .operand_b_ex_o       (op_b_ex),
    .data_misaligned_ex_o (misal_ex),
    .ex_valid_o           (ex_valid),
    .lsu_ready_ex_i       (ready_ex),
    .lsu_ready_wb_i       (ready_wb),
    .data_misaligned_i    (misal),
    .load_err_i           (load_err),
    .store_err_i          (store_err)
  );

  load_store_unit u_lsu (
    .clk                  (clk),
    .rst_n                (rst_n),
    .data_req_o           (mem_req),
    .data_gnt_i           (mem_gnt),
    .data_rvalid_i        (mem_rvalid),
    .data_err_i           (mem_err),
    .data_addr_o          (mem_addr),
    .data_we_o            (mem_we),
    .data_be_o            (mem_be),
    .data_wdata_o         (mem_wdata),
    .data_rdata_i         (mem_rdata),
    .data_we_ex_i         (we_ex),
    .data_type_ex_i       (type_ex),
    .data_wdata_ex_i      (wdata_ex),
    .data_sign_ext_ex_i   (sext_ex),
    .data_rdata_ex_o      (rdata_o),
    .data_req_ex_i        (req_ex),
    .operand_a_ex_i       (op_a_ex),
    .operand_b_ex_i       (op_b_ex),
    .addr_useincr_ex_i    (1'b1),
    .data_misaligned_ex_i (misal_ex),
    .data_misaligned_o    (misal),
    .load_err_o           (load_err),
    .store_err_o          (store_err),
    .lsu_ready_ex_o       (ready_ex),
    .lsu_ready_wb_o       (ready_wb),
    .ex_valid_i           (ex_valid),
    .busy_o               ()
  );

  data_sram u_sram (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_i       (mem_req),
    .addr_i      (mem_addr),
    .we_i        (mem_we),
    .be_i        (mem_be),
    .wdata_i     (mem_wdata),
    .err_base_i  (err_base),
    .err_limit_i (err_limit),
    .gnt_o       (mem_gnt),
    .rvalid_o    (mem_rvalid),
    .rdata_o     (mem_rdata),
    .err_o       (mem_err)
  );

  sram_err_regs u_err_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg_we_i    (cfg_we_i),
    .cfg_sel_i   (cfg_sel_i),
    .cfg_wdata_i (cfg_wdata_i),
    .err_base_o  (err_base),
    .err_limit_o (err_limit)
  );

endmodule

/* hdl/mem_access_pkg.sv */
/*
 * Types shared by the load/store unit and its memory side.
 * mem_size_e keeps the 2-bit data type encoding of the EX stage,
 * so bit 1 means byte and bit 0 means halfword.
 */
package mem_access_pkg;

  // access size
  typedef enum logic [1:0] {
    SIZE_WORD = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_BYTE = 2'b10
  } mem_size_e;

  // which access the next response belongs to
  typedef enum logic [1:0] {
    RESP_REGULAR,
    RESP_MISALIGNED,
    RESP_ALIGNED
  } resp_kind_e;

  // request/response FSM of the LSU
  typedef enum logic [1:0] {
    IDLE,
    WAIT_RVALID,
    WAIT_RVALID_EX_STALL,
    IDLE_EX_STALL
  } lsu_state_e;

endpackage

/* hdl/sram_err_regs.sv */
/*
 * Error window registers for the data memory.
 * Writes take the word address only, the low two bits are dropped.
 * Reset leaves the window empty.
 */
`timescale 1ns/1ps
`include "lsu_config.svh"

module sram_err_regs (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   cfg_we_i,
  // 0 selects base, 1 selects limit
  input  logic                   cfg_sel_i,
  input  logic [`LSU_DATA_W-1:0] cfg_wdata_i,
  output logic [`LSU_DATA_W-1:0] err_base_o,
  output logic [`LSU_DATA_W-1:0] err_limit_o
);

  logic [`LSU_DATA_W-1:0] wdata_word;

  assign wdata_word = {cfg_wdata_i[`LSU_DATA_W-1:2], 2'b00};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_base_o  <= `ERR_BASE_RST;
      err_limit_o <= `ERR_LIMIT_RST;
    end else if (cfg_we_i) begin
      if (cfg_sel_i) begin
        err_limit_o <= wdata_word;
      end else begin
        err_base_o <= wdata_word;
      end
    end
  end

endmodule

/* lsu_subsys.f */
+incdir+hdl
hdl/mem_access_pkg.sv
hdl/issue_pkg.sv
hdl/sram_err_regs.sv
hdl/data_sram.sv
hdl/load_store_unit.sv
hdl/lsu_issue_ctrl.sv
hdl/lsu_subsys.sv
dv/tb_lsu_subsys.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the load/store subsystem testbench with Verilator.
# Exit status is 0 only when the run reports a pass.
set -u
cd "$(dirname "$0")" || exit 1

TOP=tb_lsu_subsys
BUILD_DIR=obj_dir

verilator --binary -Wno-fatal -f lsu_subsys.f --top-module "$TOP" -Mdir "$BUILD_DIR"
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

sim_out=$("./$BUILD_DIR/V$TOP")
status=$?
echo "$sim_out"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qxF "Simulation finished: PASS" <<< "$sim_out"; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1
